/* vlog.f */
+incdir+hdl
hdl/roadPkg.sv
hdl/navPkg.sv
hdl/trackSampler.sv
hdl/routeNavigator.sv
hdl/statusDisplay.sv
hdl/motorDrive.sv
hdl/lineCarTop.sv
bench/lineCarTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module lineCarTb -f vlog.f -o lineCarSim

status=0
output=$(./obj_dir/lineCarSim 2>&1) || status=$?
printf '%s\n' "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
exit 1

/* bench/lineCarTb.sv */
`timescale 1ns/1ps
`include "lineCar_defs.svh"

module lineCarTb;
    import roadPkg::*;
    import navPkg::*;

    // one step of the route with the outputs expected at its end
    typedef struct packed {
        sensorBits_t sensors;
        logic        run;
        logic        glitch;
        logic [7:0]  hold;
        logic [4:0]  statePat;
        sensorBits_t roadShown;
        digitCodes_t digits;
        logic [1:0]  leftDir;
        logic [1:0]  rightDir;
        logic [3:0]  leftDuty;
        logic [3:0]  rightDuty;
    } stimRow_t;

    localparam logic [3:0] fullDuty = 4'(`PWM_PERIOD);
    localparam logic [3:0] slowDuty = 4'(`SLOW_DUTY);

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    digitCodes_t digits;
    wheelDrive_t wheels;

    stimRow_t    rows[$];
    integer      seed;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    lineCarTop u_dut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .leftTrack  (leftTrack),
        .midTrack   (midTrack),
        .rightTrack (rightTrack),
        .led        (led),
        .digits     (digits),
        .wheels     (wheels)
    );

    always #4 clk = ~clk;

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
            failRun($sformatf("timeout: the test did not end within %0d cycles", cycleLimit));
    end

    task automatic driveInputs(input sensorBits_t reading, input logic runOn);
        leftTrack  = reading.left;
        midTrack   = reading.mid;
        rightTrack = reading.right;
        run        = runOn;
    endtask

    // digits given as one hex word, d0 in the top nibble
    task automatic addRow(input logic [2:0] reading, input logic runOn, input logic glitchOn,
                          input int holdCycles, input logic [4:0] pattern,
                          input logic [2:0] shown, input logic [15:0] digitWord,
                          input logic [1:0] lDir, input logic [1:0] rDir,
                          input logic [3:0] lDuty, input logic [3:0] rDuty);
        stimRow_t r;
        r.sensors   = reading;
        r.run       = runOn;
        r.glitch    = glitchOn;
        r.hold      = 8'(holdCycles);
        r.statePat  = pattern;
        r.roadShown = shown;
        r.digits    = digitWord;
        r.leftDir   = lDir;
        r.rightDir  = rDir;
        r.leftDuty  = lDuty;
        r.rightDuty = rDuty;
        rows.push_back(r);
    endtask

    task automatic loadRows();
        // reset state, then start and the countdown
        addRow(3'b000, 1'b0, 1'b0, 4, 5'b00000, 3'b000, 16'h1CDE, dirOff, dirOff,
               4'd0, 4'd0);
        addRow(3'b010, 1'b1, 1'b0, 3, 5'b00001, 3'b000, 16'hBBBB, dirOff, dirOff,
               4'd0, 4'd0);
        addRow(3'b010, 1'b1, 1'b0, 6, 5'b00010, 3'b010, 16'hBBB3, dirOff, dirOff,
               4'd0, 4'd0);
        addRow(3'b010, 1'b1, 1'b0, 40, 5'b01000, 3'b010, 16'hA2B0, dirForward, dirForward,
               fullDuty, fullDuty);
        // short littleLeft pulse must be filtered out
        addRow(3'b100, 1'b1, 1'b1, 10, 5'b01000, 3'b010, 16'hA2B0, dirForward, dirForward,
               fullDuty, fullDuty);
        addRow(3'b100, 1'b1, 1'b0, 16, 5'b01000, 3'b100, 16'hA2B0, dirForward, dirForward,
               slowDuty, fullDuty);
        // lost line, stop then back
        addRow(3'b000, 1'b1, 1'b0, 8, 5'b11100, 3'b000, 16'h000B, dirOff, dirOff,
               4'd0, 4'd0);
        addRow(3'b000, 1'b1, 1'b0, 24, 5'b01010, 3'b000, 16'hB00B, dirBackward, dirBackward,
               fullDuty, fullDuty);
        // junction in back resumes left after the pause
        addRow(3'b111, 1'b1, 1'b0, 8, 5'b11100, 3'b111, 16'h000D, dirOff, dirOff,
               4'd0, 4'd0);
        addRow(3'b111, 1'b1, 1'b0, 24, 5'b10000, 3'b111, 16'hA3B0, dirBackward, dirForward,
               fullDuty, fullDuty);
        addRow(3'b111, 1'b0, 1'b0, 3, 5'b00000, 3'b111, 16'h1CDE, dirOff, dirOff,
               4'd0, 4'd0);
        // second run, dropped while driving straight
        addRow(3'b010, 1'b1, 1'b0, 50, 5'b01000, 3'b010, 16'hA2B0, dirForward, dirForward,
               fullDuty, fullDuty);
        addRow(3'b010, 1'b0, 1'b0, 2, 5'b00000, 3'b010, 16'h1CDE, dirOff, dirOff,
               4'd0, 4'd0);
    endtask

    // only the state pattern and the road field are compared
    task automatic checkLed(input logic [15:0] actual, input logic [15:0] expected,
                            input logic [15:0] mask, input string label);
        if ((actual & mask) !== (expected & mask))
            failRun($sformatf("error at %0t ns: %s led %b, expected %b under mask %b",
                              $time, label, actual, expected, mask));
    endtask

    task automatic checkDigits(input digitCodes_t actual, input digitCodes_t expected,
                               input string label);
        if (actual !== expected)
            failRun($sformatf("error at %0t ns: %s digits %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                              $time, label, actual.d0, actual.d1, actual.d2, actual.d3,
                              expected.d0, expected.d1, expected.d2, expected.d3));
    endtask

    task automatic checkWheels(input wheelDrive_t actual, input wheelDrive_t expected,
                               input string label);
        if (actual.leftDir !== expected.leftDir || actual.rightDir !== expected.rightDir)
            failRun($sformatf("error at %0t ns: %s wheel dirs %b %b, expected %b %b",
                              $time, label, actual.leftDir, actual.rightDir,
                              expected.leftDir, expected.rightDir));
    endtask

    // high cycles of each pwm over one full period
    task automatic checkDuty(input int leftHigh, input int rightHigh,
                             input logic [3:0] leftExp, input logic [3:0] rightExp,
                             input string label);
        if (leftHigh != int'(leftExp) || rightHigh != int'(rightExp))
            failRun($sformatf("error at %0t ns: %s pwm duty %0d %0d, expected %0d %0d",
                              $time, label, leftHigh, rightHigh, leftExp, rightExp));
    endtask

    initial begin
        stimRow_t    row;
        wheelDrive_t expWheels;
        sensorBits_t prevReading;
        int          glitchLen;
        int          holdTotal;
        int          leftHigh;
        int          rightHigh;

        seed = 61;
        rst  = 1'b1;
        driveInputs(3'b000, 1'b0);
        prevReading = 3'b000;
        loadRows();
        holdTotal = 0;
        foreach (rows[i])
            holdTotal = holdTotal + int'(rows[i].hold);
        cycleLimit = holdTotal + 100;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            if (row.glitch) begin
                // pulse shorter than the filter window, then back to the old reading
                glitchLen = 1 + int'({$random(seed)} % (`FILTER_CYCLES - 1));
                driveInputs(row.sensors, row.run);
                repeat (glitchLen) @(posedge clk);
                #1;
                driveInputs(prevReading, row.run);
            end else begin
                driveInputs(row.sensors, row.run);
                prevReading = row.sensors;
            end
            leftHigh  = 0;
            rightHigh = 0;
            for (int c = 0; c < int'(row.hold); c++) begin
                @(posedge clk);
                #1;
                // the last full pwm period of the row
                if (c >= int'(row.hold) - `PWM_PERIOD) begin
                    leftHigh  = leftHigh + int'(wheels.leftPwm);
                    rightHigh = rightHigh + int'(wheels.rightPwm);
                end
            end
            expWheels = '{leftDir: row.leftDir, rightDir: row.rightDir,
                          leftPwm: 1'b0, rightPwm: 1'b0};
            checkLed(led, {row.statePat, 8'h00, row.roadShown}, 16'hF807,
                     $sformatf("row %0d", i));
            checkDigits(digits, row.digits, $sformatf("row %0d", i));
            checkWheels(wheels, expWheels, $sformatf("row %0d", i));
            if (row.leftDir != dirOff || row.rightDir != dirOff)
                checkDuty(leftHigh, rightHigh, row.leftDuty, row.rightDuty,
                          $sformatf("row %0d", i));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* hdl/lineCarTop.sv */
`timescale 1ns/1ps

module lineCarTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                leftTrack,
    input  logic                midTrack,
    input  logic                rightTrack,
    output logic [15:0]         led,
    output navPkg::digitCodes_t digits,
    output navPkg::wheelDrive_t wheels
);
    import roadPkg::*;
    import navPkg::*;

    roadReading_u road;
    logic         roadStrobe;
    navState_e    state;
    logic [1:0]   countDigit;
    navState_e    storedMove;
    logic         flashOn;

    trackSampler u_sampler (
        .clk        (clk),
        .rst        (rst),
        .leftTrack  (leftTrack),
        .midTrack   (midTrack),
        .rightTrack (rightTrack),
        .road       (road),
        .roadStrobe (roadStrobe)
    );

    routeNavigator u_nav (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .road       (road),
        .roadStrobe (roadStrobe),
        .state      (state),
        .countDigit (countDigit),
        .storedMove (storedMove),
        .flashOn    (flashOn)
    );

    // display and motor both follow the navigator state
    statusDisplay u_display (
        .state      (state),
        .countDigit (countDigit),
        .storedMove (storedMove),
        .flashOn    (flashOn),
        .road       (road),
        .led        (led),
        .digits     (digits)
    );

    motorDrive u_motor (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .wheels (wheels)
    );

endmodule

/* hdl/motorDrive.sv */
`timescale 1ns/1ps
`include "lineCar_defs.svh"

module motorDrive (
    input  logic                clk,
    input  logic                rst,
    input  navPkg::navState_e   state,
    output navPkg::wheelDrive_t wheels
);
    import navPkg::*;

    localparam int cntW = $clog2(`PWM_PERIOD);
    localparam logic [3:0] fullDuty = 4'(`PWM_PERIOD);
    localparam logic [3:0] slowDuty = 4'(`SLOW_DUTY);

    logic [cntW-1:0] pwmCnt;
    logic [3:0]      leftDuty;
    logic [3:0]      rightDuty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pwmCnt <= '0;
        else if (pwmCnt == cntW'(`PWM_PERIOD - 1))
            pwmCnt <= '0;
        else
            pwmCnt <= pwmCnt + 1'b1;
    end

    always_comb begin
        wheels.leftDir  = dirOff;
        wheels.rightDir = dirOff;
        leftDuty        = 4'd0;
        rightDuty       = 4'd0;
        case (state)
            straight, littleLeft, littleRight: begin
                wheels.leftDir  = dirForward;
                wheels.rightDir = dirForward;
                // the inner wheel slows down for a small correction
                leftDuty  = (state == littleLeft) ? slowDuty : fullDuty;
                rightDuty = (state == littleRight) ? slowDuty : fullDuty;
            end
            left, right, back: begin
                wheels.leftDir  = (state == left || state == back) ? dirBackward : dirForward;
                wheels.rightDir = (state == right || state == back) ? dirBackward : dirForward;
                leftDuty        = fullDuty;
                rightDuty       = fullDuty;
            end
            default: begin
                leftDuty  = 4'd0;
                rightDuty = 4'd0;
            end
        endcase
        wheels.leftPwm  = 4'(pwmCnt) < leftDuty;
        wheels.rightPwm = 4'(pwmCnt) < rightDuty;
    end

    pwmOffLeft: assert property (@(posedge clk) disable iff (rst)
        (wheels.leftDir == dirOff) |-> !wheels.leftPwm);
    pwmOffRight: assert property (@(posedge clk) disable iff (rst)
        (wheels.rightDir == dirOff) |-> !wheels.rightPwm);

endmodule

/* hdl/statusDisplay.sv */
`timescale 1ns/1ps

module statusDisplay (
    input  navPkg::navState_e     state,
    input  logic [1:0]            countDigit,
    input  navPkg::navState_e     storedMove,
    input  logic                  flashOn,
    input  roadPkg::roadReading_u road,
    output logic [15:0]           led,
    output navPkg::digitCodes_t   digits
);
    import navPkg::*;

    logic [4:0] stateBits;
    logic [5:0] middle;
    logic [3:0] moveCode;

    // last digit in back and stop shows where the car resumes
    always_comb begin
        case (storedMove)
            idle:     moveCode = 4'd12;
            straight: moveCode = 4'd1;
            left:     moveCode = 4'd13;
            right:    moveCode = 4'd15;
            back:     moveCode = 4'd11;
            default:  moveCode = 4'd0;
        endcase
    end

    always_comb begin
        stateBits = 5'b00000;
        middle    = 6'b000000;
        digits    = '{4'd0, 4'd0, 4'd0, 4'd0};
        case (state)
            idle: begin
                digits = '{4'd1, 4'd12, 4'd13, 4'd14};
            end
            start: begin
                stateBits = 5'b00001;
                digits    = '{4'd11, 4'd11, 4'd11, 4'd11};
            end
            count: begin
                stateBits = 5'b00010;
                middle    = flashOn ? 6'b000000 : 6'b111111;
                digits    = '{4'd11, 4'd11, 4'd11, {2'b00, 2'd3 - countDigit}};
            end
            straight: begin
                stateBits = 5'b01000;
                middle    = 6'b001100;
                digits    = '{4'd10, 4'd2, 4'd11, 4'd0};
            end
            littleLeft, littleRight: begin
                stateBits = 5'b01000;
                digits    = '{4'd10, 4'd2, 4'd11, 4'd0};
            end
            choose: begin
                stateBits = 5'b11100;
                digits    = '{4'd10, 4'd1, 4'd11, 4'd0};
            end
            left: begin
                stateBits = 5'b10000;
                middle    = 6'b110000;
                digits    = '{4'd10, 4'd3, 4'd11, 4'd0};
            end
            right: begin
                stateBits = 5'b00100;
                middle    = 6'b000011;
                digits    = '{4'd10, 4'd4, 4'd11, 4'd0};
            end
            back: begin
                stateBits = 5'b01010;
                middle    = flashOn ? 6'b000000 : 6'b111111;
                digits    = '{4'd11, 4'd0, 4'd0, moveCode};
            end
            stop: begin
                stateBits = 5'b11100;
                middle    = 6'b111111;
                digits    = '{4'd0, 4'd0, 4'd0, moveCode};
            end
            error: stateBits = 5'b11111;
            default: stateBits = 5'b00000;
        endcase
    end

    assign led = {stateBits, 1'b0, middle, 1'b0, road.sensors};

endmodule

/* hdl/routeNavigator.sv */
`timescale 1ns/1ps
`include "lineCar_defs.svh"

module routeNavigator (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  roadPkg::roadReading_u road,
    input  logic                  roadStrobe,
    output navPkg::navState_e     state,
    output logic [1:0]            countDigit,
    output navPkg::navState_e     storedMove,
    output logic                  flashOn
);
    import roadPkg::*;
    import navPkg::*;

    navState_e  nextState;
    navState_e  nextMove;
    logic [4:0] timer;
    logic [2:0] flashTimer;
    logic       straightCp;
    logic       chooseCp;
    logic       leftCp;
    logic       rightCp;
    logic [1:0] rightCount;
    logic       backDone;
    logic       inStraight;
    logic       notJunction;
    logic       countEnd;
    logic       stopEnd;

    assign inStraight  = state inside {straight, navPkg::littleLeft, navPkg::littleRight};
    assign notJunction = road.code != turn111;
    assign countEnd    = (countDigit == 2'd3) && (timer == 5'(`COUNT_CYCLES - 1));
    assign stopEnd     = timer == 5'(`STOP_CYCLES - 1);

    always_comb begin
        nextState = state;
        nextMove  = storedMove;
        case (state)
            idle: if (run) nextState = start;
            start: if (road.code == straightRoad) nextState = count;
            count: if (countEnd) nextState = straight;
            straight, navPkg::littleLeft, navPkg::littleRight: begin
                case (road.code)
                    errorRoad: begin
                        nextState = stop;
                        nextMove  = back;
                    end
                    turn111:              nextState = straightCp ? choose : straight;
                    roadPkg::littleLeft:  nextState = navPkg::littleLeft;
                    roadPkg::littleRight: nextState = navPkg::littleRight;
                    default:              nextState = straight;
                endcase
            end
            choose: begin
                if (chooseCp && road.code == turn111) begin
                    nextState = straight;
                end else if (chooseCp && road.code == turn101) begin
                    nextState = stop;
                    nextMove  = left;
                end
            end
            left: begin
                if (leftCp && road.code == turn111) begin
                    nextState = stop;
                    nextMove  = straight;
                end
            end
            right: begin
                // second junction crossed, the next one ends the right leg
                if (rightCount >= 2'd2 && road.code == turn111) begin
                    nextState = stop;
                    nextMove  = straight;
                end else if (rightCount >= 2'd2 && road.code == turn101) begin
                    nextState = error;
                end
            end
            back: begin
                if (road.code == turn111) begin
                    nextState = stop;
                    nextMove  = backDone ? right : left;
                end
            end
            stop: if (stopEnd) nextState = storedMove;
            error: nextState = error;
            default: nextState = idle;
        endcase
        // run switch off overrides everything
        if (!run)
            nextState = idle;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            storedMove <= idle;
            timer      <= '0;
            countDigit <= '0;
        end else begin
            state      <= nextState;
            storedMove <= nextMove;
            // timers restart on every state entry
            if (nextState != state) begin
                timer      <= '0;
                countDigit <= '0;
            end else if (state == count && timer == 5'(`COUNT_CYCLES - 1)) begin
                timer      <= '0;
                countDigit <= countDigit + 2'd1;
            end else begin
                timer <= timer + 5'd1;
            end
        end
    end

    // checkpoints arm once the car has left the junction it entered on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            straightCp <= 1'b0;
            chooseCp   <= 1'b0;
            leftCp     <= 1'b0;
            rightCp    <= 1'b0;
            rightCount <= '0;
            backDone   <= 1'b0;
        end else begin
            straightCp <= inStraight ? (straightCp || notJunction) : (state == count);
            chooseCp   <= (state == choose) && (chooseCp || notJunction);
            leftCp     <= (state == left) && (leftCp || notJunction);
            rightCp    <= (state == right) && (rightCp || notJunction);
            if (state != right)
                rightCount <= '0;
            else if (rightCp && roadStrobe && !notJunction && rightCount != 2'd3)
                rightCount <= rightCount + 2'd1;
            if (state == idle)
                backDone <= 1'b0;
            else if (state == back && !notJunction)
                backDone <= 1'b1;
        end
    end

    // blink source for count and back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flashTimer <= '0;
            flashOn    <= 1'b0;
        end else if (state inside {count, back}) begin
            if (flashTimer == 3'(`FLASH_CYCLES - 1)) begin
                flashTimer <= '0;
                flashOn    <= !flashOn;
            end else begin
                flashTimer <= flashTimer + 3'd1;
            end
        end else begin
            flashTimer <= '0;
            flashOn    <= 1'b0;
        end
    end

    stateLegal: assert property (@(posedge clk) disable iff (rst)
        state inside {idle, start, count, straight, choose, left, right, back,
                      navPkg::littleLeft, navPkg::littleRight, stop, error});

endmodule

/* hdl/trackSampler.sv */
`timescale 1ns/1ps
`include "lineCar_defs.svh"

module trackSampler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  leftTrack,
    input  logic                  midTrack,
    input  logic                  rightTrack,
    output roadPkg::roadReading_u road,
    output logic                  roadStrobe
);
    import roadPkg::*;

    sensorBits_t syncFirst;
    sensorBits_t syncSecond;
    logic [3:0]  stableCnt;
    logic        accept;

    // syncFirst is the value syncSecond takes next, so equal means it holds
    assign accept = (syncFirst == syncSecond)
                 && (stableCnt == 4'(`FILTER_CYCLES - 1))
                 && (syncSecond != road.sensors);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncFirst  <= '0;
            syncSecond <= '0;
            stableCnt  <= '0;
            road.code  <= errorRoad;
            roadStrobe <= 1'b0;
        end else begin
            syncFirst  <= '{leftTrack, midTrack, rightTrack};
            syncSecond <= syncFirst;
            // restart the stability count on any change
            if (syncFirst != syncSecond)
                stableCnt <= '0;
            else if (stableCnt != 4'(`FILTER_CYCLES))
                stableCnt <= stableCnt + 4'd1;
            roadStrobe <= accept;
            if (accept)
                road.sensors <= syncSecond;
        end
    end

    // an accepted reading must hold for a full filter window before the next one
    strobeSingle: assert property (@(posedge clk) disable iff (rst)
        roadStrobe |=> !roadStrobe);

endmodule

/* hdl/navPkg.sv */
package navPkg;

    typedef enum logic [4:0] {
        idle        = 5'd0,
        start       = 5'd1,
        count       = 5'd2,
        straight    = 5'd3,
        choose      = 5'd4,
        left        = 5'd5,
        right       = 5'd6,
        back        = 5'd7,
        littleLeft  = 5'd8,
        littleRight = 5'd9,
        stop        = 5'd30,
        error       = 5'd31
    } navState_e;

    // d0 is the leftmost digit
    typedef struct packed {
        logic [3:0] d0;
        logic [3:0] d1;
        logic [3:0] d2;
        logic [3:0] d3;
    } digitCodes_t;

    // wheel direction encodings
    localparam logic [1:0] dirForward  = 2'b10;
    localparam logic [1:0] dirBackward = 2'b01;
    localparam logic [1:0] dirOff      = 2'b00;

    typedef struct packed {
        logic [1:0] leftDir;
        logic [1:0] rightDir;
        logic       leftPwm;
        logic       rightPwm;
    } wheelDrive_t;

endpackage

/* hdl/roadPkg.sv */
package roadPkg;

    // filtered reading of the three track sensors, left in the msb
    typedef enum logic [2:0] {
        errorRoad    = 3'b000,
        littleRight  = 3'b001,
        straightRoad = 3'b010,
        rightRoad    = 3'b011,
        littleLeft   = 3'b100,
        turn101      = 3'b101,
        leftRoad     = 3'b110,
        turn111      = 3'b111
    } roadCode_e;

    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } sensorBits_t;

    // navigation decodes the word as a code, the display as raw sensors
    typedef union packed {
        roadCode_e   code;
        sensorBits_t sensors;
    } roadReading_u;

endpackage

/* hdl/lineCar_defs.svh */
`ifndef LINECAR_DEFS_SVH
`define LINECAR_DEFS_SVH

// clocks a raw sensor word must stay stable before it is accepted
`define FILTER_CYCLES 4

// length of one countdown step, four steps in total
`define COUNT_CYCLES 8

// pause before resuming the stored move
`define STOP_CYCLES 16

// half period of the led flashing in count and back
`define FLASH_CYCLES 4

// pwm period and the reduced duty for small corrections
`define PWM_PERIOD 8
`define SLOW_DUTY 3

`endif
